// ==== boundary_search.sv ====
`timescale 1ns/1ps

module boundary_search import bsearch_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rstn,
	input  logic                 i_trig,
	output logic                 o_done,
	input  logic [GAP_BITS-1:0]  i_max_gap,
	input  row_idx_t             i_start_row,
	input  row_t                 i_start_row_data,
	output logic                 o_ram_en,
	output logic                 o_ram_we,
	output logic [ADDR_BITS-1:0] o_ram_addr,
	output word_t                o_ram_wdata,
	input  word_t                i_ram_rdata,
	input  logic                 i_ram_done
);

	ram_xfer_if rd_if ();
	ram_xfer_if wr_if ();

	logic     rd_trig;
	logic     rd_done;
	logic     wr_trig;
	logic     wr_done;
	logic     sc_trig;
	logic     sc_done;
	logic     found;
	row_idx_t rd_row;
	row_idx_t wr_row;
	row_t     row_data;  // row just fetched
	row_t     mask;
	row_t     ref_row;
	col_t     left;
	col_t     right;

	row_sequencer u_row_sequencer (
		.i_clk            (i_clk),
		.i_rstn           (i_rstn),
		.i_trig           (i_trig),
		.o_done           (o_done),
		.i_start_row      (i_start_row),
		.i_start_row_data (i_start_row_data),
		.o_rd_trig        (rd_trig),
		.i_rd_done        (rd_done),
		.o_wr_trig        (wr_trig),
		.i_wr_done        (wr_done),
		.o_sc_trig        (sc_trig),
		.i_sc_done        (sc_done),
		.o_rd_row         (rd_row),
		.o_wr_row         (wr_row),
		.o_mask           (mask),
		.o_ref_row        (ref_row),
		.i_found          (found),
		.i_left           (left),
		.i_right          (right)
	);

	segment_scanner u_segment_scanner (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_trig    (sc_trig),
		.i_cur_row (row_data),
		.i_ref_row (ref_row),
		.i_max_gap (i_max_gap),
		.o_done    (sc_done),
		.o_found   (found),
		.o_left    (left),
		.o_right   (right)
	);

	row_reader u_row_reader (
		.i_clk      (i_clk),
		.i_rstn     (i_rstn),
		.i_trig     (rd_trig),
		.i_row      (rd_row),
		.o_done     (rd_done),
		.o_row_data (row_data),
		.port       (rd_if.requester)
	);

	row_writer u_row_writer (
		.i_clk  (i_clk),
		.i_rstn (i_rstn),
		.i_trig (wr_trig),
		.i_row  (wr_row),
		.i_mask (mask),
		.o_done (wr_done),
		.port   (wr_if.requester)
	);

	ram_arbiter u_ram_arbiter (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.rd_port     (rd_if.arbiter),
		.wr_port     (wr_if.arbiter),
		.o_ram_en    (o_ram_en),
		.o_ram_we    (o_ram_we),
		.o_ram_addr  (o_ram_addr),
		.o_ram_wdata (o_ram_wdata),
		.i_ram_rdata (i_ram_rdata),
		.i_ram_done  (i_ram_done)
	);

endmodule

// ==== boundary_search_chk.sv ====
`timescale 1ns/1ps

module boundary_search_chk import bsearch_pkg::*; (
	input logic                 i_clk,
	input logic                 i_rstn,
	input logic                 i_rd_req,
	input logic                 i_rd_done,
	input logic [ADDR_BITS-1:0] i_rd_addr,
	input logic                 i_wr_req,
	input logic                 i_wr_done,
	input logic [ADDR_BITS-1:0] i_wr_addr,
	input logic                 i_ram_en,
	input logic                 i_ram_done,
	input logic                 i_grant_wr
);

	int unsigned assert_errs = 0;  // read by the testbench

	// request and address hold until the word completes
	rd_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_rd_req && !i_rd_done |=> i_rd_req && $stable(i_rd_addr))
	else
	begin
		$error("read request or address changed before done");
		assert_errs++;
	end

	wr_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_wr_req && !i_wr_done |=> i_wr_req && $stable(i_wr_addr))
	else
	begin
		$error("write request or address changed before done");
		assert_errs++;
	end

	// ram enable and owner fixed for the whole word
	en_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_ram_en && !i_ram_done |=> i_ram_en && $stable(i_grant_wr))
	else
	begin
		$error("ram enable or grant changed before ram done");
		assert_errs++;
	end

	one_grant: assert property (@(posedge i_clk) disable iff (!i_rstn)
		!i_ram_en || (i_grant_wr ? i_wr_req : i_rd_req))
	else
	begin
		$error("ram port granted to an engine that is not requesting");
		assert_errs++;
	end

endmodule

bind ram_arbiter boundary_search_chk u_boundary_search_chk (
	.i_clk      (i_clk),
	.i_rstn     (i_rstn),
	.i_rd_req   (rd_port.req),
	.i_rd_done  (rd_port.done),
	.i_rd_addr  (rd_port.addr),
	.i_wr_req   (wr_port.req),
	.i_wr_done  (wr_port.done),
	.i_wr_addr  (wr_port.addr),
	.i_ram_en   (o_ram_en),
	.i_ram_done (i_ram_done),
	.i_grant_wr (grant_wr)
);

// ==== bsearch_pkg.sv ====
package bsearch_pkg;

	// row geometry
	localparam int ROW_BITS      = 512;  // columns per row
	localparam int WORD_BITS     = 32;   // ram data width
	localparam int WORDS_PER_ROW = ROW_BITS / WORD_BITS;
	localparam int WORD_IDX_BITS = $clog2(WORDS_PER_ROW);

	// ram addressing, row * 16 + word
	localparam int ROW_IDX_BITS  = 9;
	localparam int ADDR_BITS     = ROW_IDX_BITS + WORD_IDX_BITS;

	localparam int COL_BITS      = $clog2(ROW_BITS);
	localparam int GAP_BITS      = 4;    // max interval input width

	// last row of the downward scan
	localparam int LAST_ROW      = 23;

	typedef logic [ROW_BITS-1:0]     row_t;     // bit 0 is column 0
	typedef logic [WORD_BITS-1:0]    word_t;
	typedef logic [COL_BITS-1:0]     col_t;
	typedef logic [ROW_IDX_BITS-1:0] row_idx_t;

	// column scan states
	typedef enum logic [2:0] {
		S_IDLE,
		S_SEEK,    // looking for a pixel connected to the reference
		S_IN_RUN,  // inside set pixels of the segment
		S_IN_GAP,  // counting clear pixels after the run
		S_DONE
	} scan_state_t;

endpackage

// ==== ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter import bsearch_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rstn,
	ram_xfer_if.arbiter          rd_port,
	ram_xfer_if.arbiter          wr_port,
	output logic                 o_ram_en,
	output logic                 o_ram_we,
	output logic [ADDR_BITS-1:0] o_ram_addr,
	output word_t                o_ram_wdata,
	input  word_t                i_ram_rdata,
	input  logic                 i_ram_done
);

	logic busy;      // a word is in flight
	logic grant_wr;  // owner of the current word
	logic last_wr;   // port served last
	logic pick_wr;

	// on a tie the port not served last wins
	assign pick_wr = wr_port.req && (!rd_port.req || !last_wr);

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			busy     <= 1'b0;
			grant_wr <= 1'b0;
			last_wr  <= 1'b0;
		end
		else if (!busy)
		begin
			if (rd_port.req || wr_port.req)
			begin
				busy     <= 1'b1;
				grant_wr <= pick_wr;
			end
		end
		else if (i_ram_done)
		begin
			busy    <= 1'b0;  // grant released only at word end
			last_wr <= grant_wr;
		end
	end

	assign o_ram_en    = busy;
	assign o_ram_we    = busy && (grant_wr ? wr_port.we : rd_port.we);
	assign o_ram_addr  = grant_wr ? wr_port.addr : rd_port.addr;
	assign o_ram_wdata = grant_wr ? wr_port.wdata : rd_port.wdata;

	// done goes back to the granted port only
	assign rd_port.done  = busy && !grant_wr && i_ram_done;
	assign wr_port.done  = busy && grant_wr && i_ram_done;
	assign rd_port.rdata = i_ram_rdata;
	assign wr_port.rdata = i_ram_rdata;

endmodule

// ==== ram_xfer_if.sv ====
`timescale 1ns/1ps

// one word transfer between an engine and the ram arbiter
interface ram_xfer_if import bsearch_pkg::*; ();

	logic                 req;    // held until done
	logic                 we;
	logic [ADDR_BITS-1:0] addr;
	word_t                wdata;
	logic                 done;   // one cycle pulse
	word_t                rdata;  // valid with done

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

// ==== row_reader.sv ====
`timescale 1ns/1ps

module row_reader import bsearch_pkg::*; (
	input  logic          i_clk,
	input  logic          i_rstn,
	input  logic          i_trig,
	input  row_idx_t      i_row,
	output logic          o_done,
	output row_t          o_row_data,
	ram_xfer_if.requester port
);

	logic [WORD_IDX_BITS-1:0] word_cnt;
	logic                     busy;
	logic                     done_pre;
	logic                     start;
	row_idx_t                 row_q;

	assign start      = i_trig && !busy && !done_pre;
	assign port.req   = busy;
	assign port.we    = 1'b0;  // read only
	assign port.addr  = {row_q, word_cnt};
	assign port.wdata = '0;
	assign o_done     = done_pre & i_trig;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			busy     <= 1'b0;
			done_pre <= 1'b0;
			word_cnt <= '0;
			row_q    <= '0;
		end
		else
		begin
			if (!i_trig)
				done_pre <= 1'b0;
			if (start)
			begin
				busy     <= 1'b1;
				word_cnt <= '0;
				row_q    <= i_row;
			end
			else if (busy && port.done)
			begin
				if (word_cnt == WORD_IDX_BITS'(WORDS_PER_ROW - 1))
				begin
					busy     <= 1'b0;  // req drops the cycle after the last done
					done_pre <= 1'b1;
				end
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// word k fills columns 32k to 32k+31
	always_ff @(posedge i_clk)
	begin
		if (busy && port.done)
			o_row_data[word_cnt*WORD_BITS +: WORD_BITS] <= port.rdata;
	end

endmodule

// ==== row_sequencer.sv ====
`timescale 1ns/1ps

module row_sequencer import bsearch_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rstn,
	input  logic     i_trig,
	output logic     o_done,
	input  row_idx_t i_start_row,
	input  row_t     i_start_row_data,
	output logic     o_rd_trig,
	input  logic     i_rd_done,
	output logic     o_wr_trig,
	input  logic     i_wr_done,
	output logic     o_sc_trig,
	input  logic     i_sc_done,
	output row_idx_t o_rd_row,
	output row_idx_t o_wr_row,
	output row_t     o_mask,
	output row_t     o_ref_row,
	input  logic     i_found,
	input  col_t     i_left,
	input  col_t     i_right
);

	enum logic [2:0] {SEQ_IDLE, SEQ_READ, SEQ_SCAN, SEQ_WRITE, SEQ_FINISH} state;

	row_idx_t row_num;   // row under scan
	logic     done_pre;
	logic     last_row;
	logic     rd_ok;
	row_t     range_mask;

	assign last_row = (row_num == row_idx_t'(LAST_ROW));
	assign rd_ok    = i_rd_done || !o_rd_trig;  // no read after the last row
	assign o_done   = done_pre & i_trig;
	assign o_wr_row = row_num;
	assign o_mask   = o_ref_row;  // written mask doubles as the next reference

	always_comb
	begin
		for (int c = 0; c < ROW_BITS; c++)
			range_mask[c] = i_found && (c >= int'(i_left)) && (c <= int'(i_right));
	end

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			state     <= SEQ_IDLE;
			row_num   <= '0;
			done_pre  <= 1'b0;
			o_rd_trig <= 1'b0;
			o_wr_trig <= 1'b0;
			o_sc_trig <= 1'b0;
			o_rd_row  <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (i_trig)
					begin
						row_num   <= i_start_row + 1'b1;
						o_rd_row  <= i_start_row + 1'b1;
						o_rd_trig <= 1'b1;
						state     <= SEQ_READ;
					end
				end
				SEQ_READ:
				begin
					if (i_rd_done)
					begin
						o_rd_trig <= 1'b0;
						o_sc_trig <= 1'b1;
						state     <= SEQ_SCAN;
					end
				end
				SEQ_SCAN:
				begin
					if (i_sc_done)
					begin
						o_sc_trig <= 1'b0;
						o_wr_trig <= 1'b1;
						if (!last_row)
						begin
							o_rd_trig <= 1'b1;  // next read overlaps this write-back
							o_rd_row  <= row_num + 1'b1;
						end
						state <= SEQ_WRITE;
					end
				end
				SEQ_WRITE:
				begin
					if (i_wr_done && rd_ok)
					begin
						o_wr_trig <= 1'b0;
						o_rd_trig <= 1'b0;
						if (last_row)
							state <= SEQ_FINISH;
						else
						begin
							row_num   <= row_num + 1'b1;
							o_sc_trig <= 1'b1;
							state     <= SEQ_SCAN;
						end
					end
				end
				SEQ_FINISH:
				begin
					done_pre <= 1'b1;
					if (!i_trig)
					begin
						done_pre <= 1'b0;
						state    <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// reference starts as the given start row, then follows each mask
	always_ff @(posedge i_clk)
	begin
		if (state == SEQ_IDLE && i_trig)
			o_ref_row <= i_start_row_data;
		else if (state == SEQ_SCAN && i_sc_done)
			o_ref_row <= range_mask;
	end

endmodule

// ==== row_writer.sv ====
`timescale 1ns/1ps

module row_writer import bsearch_pkg::*; (
	input  logic          i_clk,
	input  logic          i_rstn,
	input  logic          i_trig,
	input  row_idx_t      i_row,
	input  row_t          i_mask,
	output logic          o_done,
	ram_xfer_if.requester port
);

	logic [WORD_IDX_BITS-1:0] word_cnt;
	logic                     busy;
	logic                     done_pre;
	logic                     start;
	row_idx_t                 row_q;
	row_t                     mask_q;

	assign start      = i_trig && !busy && !done_pre;
	assign port.req   = busy;
	assign port.we    = 1'b1;
	assign port.addr  = {row_q, word_cnt};
	assign port.wdata = mask_q[word_cnt*WORD_BITS +: WORD_BITS];
	assign o_done     = done_pre & i_trig;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			busy     <= 1'b0;
			done_pre <= 1'b0;
			word_cnt <= '0;
			row_q    <= '0;
		end
		else
		begin
			if (!i_trig)
				done_pre <= 1'b0;
			if (start)
			begin
				busy     <= 1'b1;
				word_cnt <= '0;
				row_q    <= i_row;  // sequencer may move on after this
			end
			else if (busy && port.done)
			begin
				if (word_cnt == WORD_IDX_BITS'(WORDS_PER_ROW - 1))
				begin
					busy     <= 1'b0;
					done_pre <= 1'b1;
				end
				else
					word_cnt <= word_cnt + 1'b1;  // next word presented at once
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (start)
			mask_q <= i_mask;
	end

endmodule

// ==== segment_scanner.sv ====
`timescale 1ns/1ps

module segment_scanner import bsearch_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rstn,
	input  logic                i_trig,
	input  row_t                i_cur_row,
	input  row_t                i_ref_row,
	input  logic [GAP_BITS-1:0] i_max_gap,
	output logic                o_done,
	output logic                o_found,
	output col_t                o_left,
	output col_t                o_right
);

	scan_state_t         state;
	col_t                col_cnt;
	logic [GAP_BITS-1:0] gap_cnt;   // clear columns in the current gap
	logic                done_pre;
	logic                scanning;
	logic                last_col;
	logic                cur_pix;
	logic                ref_pix;
	row_t                cur_sh;
	row_t                ref_sh;

	assign cur_pix  = cur_sh[0];
	assign ref_pix  = ref_sh[0];
	assign scanning = (state == S_SEEK) || (state == S_IN_RUN) || (state == S_IN_GAP);
	assign last_col = (col_cnt == col_t'(ROW_BITS - 1));
	assign o_done   = done_pre & i_trig;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			state    <= S_IDLE;
			col_cnt  <= '0;
			gap_cnt  <= '0;
			done_pre <= 1'b0;
			o_found  <= 1'b0;
			o_left   <= '0;
			o_right  <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (i_trig)
					begin
						state   <= S_SEEK;  // rows latched this cycle
						col_cnt <= '0;
						gap_cnt <= '0;
						o_found <= 1'b0;
						o_left  <= '0;
						o_right <= '0;
					end
				end
				S_SEEK:
				begin
					// only the first connected column opens a segment
					if (!o_found && cur_pix && ref_pix)
					begin
						o_found <= 1'b1;
						o_left  <= col_cnt;
						o_right <= col_cnt;
						state   <= S_IN_RUN;
					end
				end
				S_IN_RUN:
				begin
					if (cur_pix)
						o_right <= col_cnt;  // right bound tracks last set column
					else if (i_max_gap == '0)
						state <= S_SEEK;     // closed, right bound frozen
					else
					begin
						gap_cnt <= GAP_BITS'(1);
						state   <= S_IN_GAP;
					end
				end
				S_IN_GAP:
				begin
					if (cur_pix)
					begin
						o_right <= col_cnt;  // gap bridged
						state   <= S_IN_RUN;
					end
					else if (gap_cnt >= i_max_gap)
						state <= S_SEEK;
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				S_DONE:
				begin
					done_pre <= 1'b1;
					if (!i_trig)
					begin
						done_pre <= 1'b0;
						state    <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase

			// full row always scanned, keeps latency fixed
			if (scanning)
			begin
				col_cnt <= col_cnt + 1'b1;
				if (last_col)
					state <= S_DONE;
			end
		end
	end

	// both rows shift right, column under test sits in bit 0
	always_ff @(posedge i_clk)
	begin
		if (state == S_IDLE && i_trig)
		begin
			cur_sh <= i_cur_row;
			ref_sh <= i_ref_row;
		end
		else if (scanning)
		begin
			cur_sh <= cur_sh >> 1;
			ref_sh <= ref_sh >> 1;
		end
	end

endmodule

// ==== tb_boundary_search.sv ====
`timescale 1ns/1ps

module tb_boundary_search import bsearch_pkg::*; ();

	localparam int MEM_WORDS = 1 << ADDR_BITS;
	localparam int TIMEOUT   = 50000;  // cycles allowed per wait

	logic                 clk;
	logic                 rstn;
	logic                 trig;
	logic                 done;
	logic [GAP_BITS-1:0]  max_gap;
	row_idx_t             start_row;
	row_t                 start_data;
	logic                 ram_en;
	logic                 ram_we;
	logic [ADDR_BITS-1:0] ram_addr;
	word_t                ram_wdata;
	word_t                ram_rdata;
	logic                 ram_done;

	word_t       mem [MEM_WORDS];      // ram model contents
	word_t       exp_mem [MEM_WORDS];  // expected image after a run
	logic        ram_busy;
	int          ram_wait;
	int          wr_words;             // words written since reset
	logic [31:0] lcg_state = 32'hd66e;
	int          word_errs;
	int          level_errs;
	int          timeouts;
	int          assert_errs;
	logic        timed_out;

	boundary_search i_boundary_search (
		.i_clk            (clk),
		.i_rstn           (rstn),
		.i_trig           (trig),
		.o_done           (done),
		.i_max_gap        (max_gap),
		.i_start_row      (start_row),
		.i_start_row_data (start_data),
		.o_ram_en         (ram_en),
		.o_ram_we         (ram_we),
		.o_ram_addr       (ram_addr),
		.o_ram_wdata      (ram_wdata),
		.i_ram_rdata      (ram_rdata),
		.i_ram_done       (ram_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ram answers each word after 1 to 4 cycles
	always @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			ram_done <= 1'b0;
			ram_busy <= 1'b0;
			ram_wait <= 0;
			wr_words <= 0;
		end
		else
		begin
			ram_done <= 1'b0;
			if (ram_busy)
			begin
				if (ram_wait <= 1)
				begin
					ram_done  <= 1'b1;
					ram_busy  <= 1'b0;
					ram_rdata <= mem[ram_addr];
					if (ram_we)
					begin
						mem[ram_addr] <= ram_wdata;
						wr_words      <= wr_words + 1;
					end
				end
				else
					ram_wait <= ram_wait - 1;
			end
			else if (ram_en && !ram_done)  // en still high in the done cycle
			begin
				lcg_state = lcg_next(lcg_state);
				ram_busy <= 1'b1;
				ram_wait <= int'(lcg_state[17:16]) + 1;
			end
		end
	end

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			word_errs++;
			$display("mismatch %s expected %08h actual %08h", name, exp, act);
		end
	endtask

	task automatic compare_level(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			level_errs++;
			$display("mismatch %s expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic word_t fill_word(input logic [ADDR_BITS-1:0] a);
		return {3'b101, a, 3'b010, ~a};
	endfunction

	function automatic row_t span(input int lo, input int hi);
		row_t r;
		r = '0;
		for (int c = lo; c <= hi; c++)
			r[c] = 1'b1;
		return r;
	endfunction

	// first connected column, then runs joined over short clear gaps
	function automatic row_t segment_mask(input row_t cur, input row_t refr, input int gap_max);
		int   left;
		int   right;
		int   gap;
		row_t m;
		left  = -1;
		right = -1;
		gap   = 0;
		for (int c = 0; c < ROW_BITS; c++)
		begin
			if (left < 0)
			begin
				if (cur[c] && refr[c])
				begin
					left  = c;
					right = c;
				end
			end
			else if (gap <= gap_max)
			begin
				if (cur[c])
				begin
					right = c;
					gap   = 0;
				end
				else
					gap++;
			end
		end
		m = '0;
		if (left >= 0)
			for (int c = left; c <= right; c++)
				m[c] = 1'b1;
		return m;
	endfunction

	task automatic fill_memory();
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = fill_word(ADDR_BITS'(a));
	endtask

	task automatic put_row(input int r, input row_t data);
		for (int w = 0; w < WORDS_PER_ROW; w++)
			mem[r*WORDS_PER_ROW + w] = data[w*WORD_BITS +: WORD_BITS];
	endtask

	// downward pass over the expected image, each mask is the next reference
	task automatic predict(input int first_row, input row_t first_data, input int gap);
		row_t refr;
		row_t cur;
		refr = first_data;
		for (int r = first_row + 1; r <= LAST_ROW; r++)
		begin
			for (int w = 0; w < WORDS_PER_ROW; w++)
				cur[w*WORD_BITS +: WORD_BITS] = exp_mem[r*WORDS_PER_ROW + w];
			refr = segment_mask(cur, refr, gap);
			for (int w = 0; w < WORDS_PER_ROW; w++)
				exp_mem[r*WORDS_PER_ROW + w] = refr[w*WORD_BITS +: WORD_BITS];
		end
	endtask

	task automatic apply_reset(input string tname);
		@(posedge clk);
		rstn <= 1'b0;
		trig <= 1'b0;
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		compare_level({tname, " reset done"}, 1'b0, done);
		compare_level({tname, " reset ram_en"}, 1'b0, ram_en);
		compare_level({tname, " reset ram_we"}, 1'b0, ram_we);
	endtask

	task automatic run_search(input string tname, input int first_row, input row_t first_data,
			input int gap);
		int n;
		apply_reset(tname);
		exp_mem = mem;
		predict(first_row, first_data, gap);
		@(posedge clk);
		start_row  <= row_idx_t'(first_row);
		start_data <= first_data;
		max_gap    <= GAP_BITS'(gap);
		trig       <= 1'b1;
		@(negedge clk);
		compare_level({tname, " early done"}, 1'b0, done);
		n = 0;
		while (!done && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!done)
		begin
			$display("%s: done did not rise within %0d cycles", tname, TIMEOUT);
			timeouts++;
			timed_out = 1'b1;
			return;
		end
		repeat (3)
		begin
			@(negedge clk);
			compare_level({tname, " held done"}, 1'b1, done);
		end
		@(posedge clk);
		trig <= 1'b0;
		@(negedge clk);
		compare_level({tname, " done release"}, 1'b0, done);
		// one write per word of every row below the start row
		compare_word({tname, " write words"},
			word_t'((LAST_ROW - first_row) * WORDS_PER_ROW), word_t'(wr_words));
		for (n = 0; n < MEM_WORDS; n++)
			compare_word($sformatf("%s addr %0d", tname, n), exp_mem[n], mem[n]);
	endtask

	task automatic test_solid_segment();
		fill_memory();
		for (int r = 5; r <= LAST_ROW; r++)
			put_row(r, span(60 + 3*r, 300 - 2*r) | span(400, 420));
		run_search("solid", 4, span(100, 200), 2);
		if (timed_out)
			return;
		compare_word("solid row 5 word 3", 32'hfffffff0, mem[5*WORDS_PER_ROW + 3]);
		compare_word("solid row 13 word 3", 32'hfffffff0, mem[13*WORDS_PER_ROW + 3]);
		compare_word("solid row 23 word 12", 32'h0, mem[23*WORDS_PER_ROW + 12]);
	endtask

	task automatic test_gap_bridge();
		fill_memory();
		for (int r = 3; r <= LAST_ROW; r++)
			put_row(r, span(40, 60) | span(64, 80) | span(85, 100));  // gaps of 3 and 4
		run_search("gap", 2, span(40, 60), 3);
		if (timed_out)
			return;
		compare_word("gap row 3 word 1", 32'hffffff00, mem[3*WORDS_PER_ROW + 1]);
		compare_word("gap row 3 word 2", 32'h0001ffff, mem[3*WORDS_PER_ROW + 2]);
		compare_word("gap row 23 word 2", 32'h0001ffff, mem[23*WORDS_PER_ROW + 2]);
		compare_word("gap row 23 word 3", 32'h0, mem[23*WORDS_PER_ROW + 3]);
	endtask

	task automatic test_lost_connection();
		fill_memory();
		for (int r = 11; r <= LAST_ROW; r++)
			put_row(r, (r == 16) ? span(300, 320) : span(190, 230));
		run_search("lost", 10, span(200, 220), 2);
		if (timed_out)
			return;
		compare_word("lost row 15 word 6", 32'hffffff00, mem[15*WORDS_PER_ROW + 6]);
		compare_word("lost row 15 word 7", 32'h0000007f, mem[15*WORDS_PER_ROW + 7]);
		compare_word("lost row 16 word 9", 32'h0, mem[16*WORDS_PER_ROW + 9]);
		for (int r = 16; r <= LAST_ROW; r++)
			compare_word($sformatf("lost row %0d word 6", r), 32'h0, mem[r*WORDS_PER_ROW + 6]);
	endtask

	initial
	begin
		rstn       = 1'b0;
		trig       = 1'b0;
		max_gap    = '0;
		start_row  = '0;
		start_data = '0;
		ram_done   = 1'b0;
		ram_rdata  = '0;
		word_errs  = 0;
		level_errs = 0;
		timeouts   = 0;
		timed_out  = 1'b0;
		test_solid_segment();
		if (!timed_out)
			test_gap_bridge();
		if (!timed_out)
			test_lost_connection();
		assert_errs = i_boundary_search.u_ram_arbiter.u_boundary_search_chk.assert_errs;
		$display("errors: word %0d, level %0d, timeout %0d, assertion %0d",
			word_errs, level_errs, timeouts, assert_errs);
		if (word_errs + level_errs + timeouts + assert_errs == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
bsearch_pkg.sv
ram_xfer_if.sv
ram_arbiter.sv
row_reader.sv
row_writer.sv
segment_scanner.sv
row_sequencer.sv
boundary_search.sv
boundary_search_chk.sv
tb_boundary_search.sv
